/* compile.f */
+incdir+include
verilog/rtpPkg.sv
verilog/spiByteIf.sv
verilog/rtpShifter.sv
verilog/gapTimer.sv
verilog/reportSequencer.sv
verilog/touchPanelTop.sv
tb/touchPanel_asserts.sv
tb/touchPanelTb.sv

/* include/rtp_defs.svh */
//****************************************************************************
// touch panel reader constants
// SPI bit timing, controller inter-byte gap and report length for an
// AR1021-style resistive touch controller
//****************************************************************************

`ifndef RTP_DEFS_SVH
`define RTP_DEFS_SVH

// clock cycles for one SPI bit, sck high for the first half
`define RTP_BIT_CYCLES 32

// sck high phase length, sdi is sampled on the last high cycle
`define RTP_HALF_CYCLES 16

// idle cycles between two byte transfers (about 50 us at 25 MHz)
`define RTP_GAP_CYCLES 1250

// bytes in one touch report, header first
`define RTP_REPORT_BYTES 5

`endif

/* tb/touchPanelTb.sv */
//****************************************************************************
// touch panel reader testbench
// SPI slave model feeding filler, aborted and complete reports, host side
// handshake with back-pressure, report and poll byte checks, timeout
//****************************************************************************

`timescale 1ns/10ps
`include "rtp_defs.svh"

module touchPanelTb import rtpPkg::*; ();

	localparam int NumTests = 6;
	localparam rtpByte_t fillerByte = 8'h4D; // idle pattern from the controller
	localparam logic [15:0] lfsrMask = 16'hB400;

	logic clk;
	logic arstN;
	logic sdo;
	logic sdi;
	logic sck;
	logic reportReq;
	logic reportAck;
	logic penDown;
	coord_t touchX;
	coord_t touchY;

	// stimulus table with one row per expected report
	string testName [NumTests];
	int holdCycles [NumTests]; // host delay before reportAck
	touchReport_u expRep [NumTests];
	int numTests = 0;
	int totalBytes = 0;

	rtpByte_t slaveQ [$]; // byte stream the slave model sends
	logic [15:0] lfsrState;
	int timeoutLimit = 0;
	int cycleCnt = 0;
	int txCount = 0; // bytes gathered from sdo
	int bitNum = 0;
	rtpByte_t curByte = 8'h00;
	rtpByte_t txGather = 8'h00;

	touchPanelTop dut (
		.clk (clk),
		.arstN (arstN),
		.sdo (sdo),
		.sdi (sdi),
		.sck (sck),
		.reportReq (reportReq),
		.reportAck (reportAck),
		.penDown (penDown),
		.touchX (touchX),
		.touchY (touchY)
	);

	// one Galois step returns the bit shifted out
	function automatic logic nextRandBit();
		logic outBit;
		outBit = lfsrState[0];
		lfsrState = lfsrState >> 1;
		if (outBit)
			lfsrState = lfsrState ^ lfsrMask;
		return outBit;
	endfunction

	function automatic logic [15:0] randBits(input int n);
		logic [15:0] v;
		v = '0;
		for (int k = 0; k < n; k++)
			v = {v[14:0], nextRandBit()};
		return v;
	endfunction

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("SIMULATION FAILED");
		$fatal(1);
	endtask

	// expected pen and coordinates come from the report fields
	task automatic checkReport(input string name, input touchReport_u exp);
		logic expPen;
		coord_t expX;
		coord_t expY;
		expPen = exp.fields.header[0]; // pen is bit 0 of the header
		expX = coord_t'(exp.fields.xHi & 8'h1F) * 128 + coord_t'(exp.fields.xLo & 8'h7F);
		expY = coord_t'(exp.fields.yHi & 8'h1F) * 128 + coord_t'(exp.fields.yLo & 8'h7F);
		if (penDown !== expPen || touchX !== expX || touchY !== expY)
			abortRun($sformatf(
				"CHECK FAILED %s: expected pen=%0d x=%0d y=%0d, actual pen=%0d x=%0d y=%0d",
				name, expPen, expX, expY, penDown, touchX, touchY));
	endtask

	task automatic checkTxByte(input string name, input rtpByte_t exp, input rtpByte_t act);
		if (act !== exp)
			abortRun($sformatf("CHECK FAILED %s: expected 0x%02h, actual 0x%02h",
				name, exp, act));
	endtask

	// queue the bytes of one row and remember the report it should yield
	task automatic addEntry(input string name, input int fill, input int abort, input bit hold);
		rtpByte_t b;
		testName[numTests] = name;
		repeat (fill)
			slaveQ.push_back(fillerByte);
		if (abort > 0) begin
			slaveQ.push_back(rtpByte_t'(randBits(8)) | 8'h80); // header that gets cut off
			for (int k = 1; k < abort; k++)
				slaveQ.push_back(rtpByte_t'(randBits(8)) & 8'h7F);
		end
		for (int k = 0; k < `RTP_REPORT_BYTES; k++) begin
			b = rtpByte_t'(randBits(8));
			b = (k == 0) ? (b | 8'h80) : (b & 8'h7F); // only the header has bit 7
			expRep[numTests].bytes[k] = b;
			slaveQ.push_back(b);
		end
		holdCycles[numTests] = hold ? (int'(randBits(11)) % 2000) + 1 : 0;
		totalBytes += fill + abort + `RTP_REPORT_BYTES;
		numTests++;
	endtask

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns period
	end

	// slave model puts the next msb on sdi 1 ns after each sck rise and gathers sdo
	initial begin
		forever begin
			@(posedge sck);
			#1;
			if (reportReq) begin
				abortRun("sck toggled while a report was waiting for the host");
			end else begin
				if (bitNum == 0)
					curByte = (slaveQ.size() != 0) ? slaveQ.pop_front() : fillerByte;
				sdi = curByte[7 - bitNum];
				txGather = {txGather[6:0], sdo};
				bitNum++;
				if (bitNum == 8) begin
					bitNum = 0;
					txCount++;
					checkTxByte($sformatf("txPoll%0d", txCount), 8'h00, txGather);
				end
			end
		end
	end

	// watchdog counts cycles from reset release
	initial begin
		@(posedge arstN);
		while (cycleCnt < timeoutLimit) begin
			@(posedge clk);
			cycleCnt++;
		end
		abortRun($sformatf("timeout: no report arrived within %0d cycles", timeoutLimit));
	end

	// any failed bound assertion ends the run
	initial begin
		wait (dut.uAsserts.errCount != 0);
		abortRun("a bound assertion on the handshakes or on sck failed");
	end

	initial begin
		sdi = 1'b0;
		reportAck = 1'b0;
		arstN = 1'b0;
		lfsrState = 16'd51;

		addEntry("plainReport", 0, 0, 1'b0);
		addEntry("fillerResync", 3, 0, 1'b0);
		addEntry("headerRestart", 1, 3, 1'b0); // header plus two bytes, then a new header
		addEntry("backPressure", 0, 0, 1'b1);
		addEntry("afterBackPressure", 2, 0, 1'b0);
		addEntry("lateRestart", 0, 4, 1'b0); // cut off just before the last byte
		timeoutLimit = totalBytes * (`RTP_GAP_CYCLES + 300) * 2;

		repeat (16) @(posedge clk);
		#1 arstN = 1'b1;

		for (int i = 0; i < numTests; i++) begin
			while (!reportReq) begin
				@(posedge clk);
				#1;
			end
			checkReport(testName[i], expRep[i]);
			repeat (holdCycles[i]) begin // host stalls while the bus stays quiet
				@(posedge clk);
				#1;
			end
			reportAck = 1'b1;
			while (reportReq) begin
				@(posedge clk);
				#1;
			end
			reportAck = 1'b0;
		end

		if (txCount != totalBytes) begin
			abortRun($sformatf("slave model saw %0d bytes, table holds %0d",
				txCount, totalBytes));
		end else begin
			$display("SIMULATION PASSED");
			$finish;
		end
	end

endmodule

/* tb/touchPanel_asserts.sv */
//****************************************************************************
// touch panel reader assertions
// byte handshake order, sck idle level and host report hold, bound into
// the top level
//****************************************************************************

`timescale 1ns/10ps

module touchPanelAsserts (
	input logic clk,
	input logic arstN,
	input logic req,
	input logic ack,
	input logic sck,
	input logic reportReq,
	input logic reportAck
);

	int errCount = 0; // failed assertions so far

	// shifter only answers a pending request
	ackNeedsReq: assert property (@(posedge clk) disable iff (!arstN)
		$rose(ack) |-> req)
		else begin
			errCount++;
			$error("byte ack rose without a request");
		end

	// no clocks on the panel wires outside a requested transfer
	sckIdleLow: assert property (@(posedge clk) disable iff (!arstN)
		(!req || ack) |-> !sck)
		else begin
			errCount++;
			$error("sck high while no byte transfer is pending");
		end

	// host request holds until the host answers
	reportHeld: assert property (@(posedge clk) disable iff (!arstN)
		(reportReq && !reportAck) |=> reportReq)
		else begin
			errCount++;
			$error("reportReq dropped before reportAck");
		end

endmodule

bind touchPanelTop touchPanelAsserts uAsserts (
	.clk (clk),
	.arstN (arstN),
	.req (spiBus.req),
	.ack (spiBus.ack),
	.sck (sck),
	.reportReq (reportReq),
	.reportAck (reportAck)
);

/* verilog/gapTimer.sv */
//****************************************************************************
// inter-byte gap timer
// keeps the SPI bus quiet for a fixed number of cycles between bytes, as
// the touch controller needs time to prepare the next one
//****************************************************************************

`timescale 1ns/10ps
`include "rtp_defs.svh"

module gapTimer (
	input logic clk,
	input logic arstN,
	input logic gapStart,
	output logic gapDone
);

	localparam int GapW = $clog2(`RTP_GAP_CYCLES + 1);
	localparam logic [GapW-1:0] loadVal = GapW'(`RTP_GAP_CYCLES - 1);

	logic [GapW-1:0] gapCnt; // cycles still to wait

	// load on start, count down to zero and stop there
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			gapCnt <= '0;
		else if (gapStart)
			gapCnt <= loadVal;
		else if (gapCnt != '0)
			gapCnt <= gapCnt - 1'b1;
	end

	// done shows up exactly RTP_GAP_CYCLES cycles after the start pulse,
	// then holds until the next start
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			gapDone <= 1'b0;
		else if (gapStart)
			gapDone <= 1'b0;
		else if (gapCnt == GapW'(1))
			gapDone <= 1'b1; // count reads one in the last waiting cycle
	end

endmodule

/* verilog/reportSequencer.sv */
//****************************************************************************
// touch report sequencer
// polls the controller with dummy bytes, resynchronises on header bytes,
// assembles five-byte reports and hands pen and X/Y to the host
//****************************************************************************

`timescale 1ns/10ps
`include "rtp_defs.svh"

module reportSequencer import rtpPkg::*; (
	input logic clk,
	input logic arstN,
	spiByteIf.master bus,
	output logic gapStart,
	input logic gapDone,
	output logic reportReq,
	input logic reportAck,
	output logic penDown,
	output coord_t touchX,
	output coord_t touchY
);

	localparam int IdxW = $clog2(`RTP_REPORT_BYTES + 1);
	localparam logic [IdxW-1:0] fullIdx = IdxW'(`RTP_REPORT_BYTES);
	localparam rtpByte_t pollByte = 8'h00; // controller only needs clocks

	// FSM encoding
	localparam logic [2:0] stGapStart = 3'd0; // kick the gap timer
	localparam logic [2:0] stGapWait = 3'd1;
	localparam logic [2:0] stXfer = 3'd2; // req high, waiting for ack
	localparam logic [2:0] stRelease = 3'd3; // req low, waiting for ack to drop
	localparam logic [2:0] stReport = 3'd4; // reportReq high
	localparam logic [2:0] stHostRelease = 3'd5; // waiting for reportAck low

	logic [2:0] state;
	logic [IdxW-1:0] byteIdx; // next report slot, 0 means hunting for a header
	touchReport_u report; // filled as bytes, read as fields
	rtpByte_t rxByte;
	logic isHeader;

	assign rxByte = bus.rxByte;
	assign isHeader = rxByte[7]; // only header bytes have bit 7 set

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state <= stGapStart; // first thing after reset is a gap
			byteIdx <= '0;
		end else begin
			case (state)
				stGapStart: state <= stGapWait;
				stGapWait: begin
					if (gapDone)
						state <= stXfer;
				end
				stXfer: begin
					if (bus.ack) begin
						state <= stRelease;
						if (isHeader)
							byteIdx <= IdxW'(1); // header always (re)starts a report
						else if (byteIdx != '0)
							byteIdx <= byteIdx + 1'b1;
						// filler while hunting leaves the index at zero
					end
				end
				stRelease: begin
					if (!bus.ack) begin
						if (byteIdx == fullIdx) begin
							byteIdx <= '0;
							state <= stReport;
						end else begin
							state <= stGapStart;
						end
					end
				end
				stReport: begin
					if (reportAck)
						state <= stHostRelease; // req drops on the next cycle
				end
				stHostRelease: begin
					if (!reportAck)
						state <= stGapStart; // resume polling only after ack low
				end
				default: state <= stGapStart;
			endcase
		end
	end

	// report bytes land at their index, a header goes to slot 0
	always_ff @(posedge clk) begin
		if (state == stXfer && bus.ack) begin
			if (isHeader)
				report.bytes[0] <= rxByte;
			else if (byteIdx != '0)
				report.bytes[byteIdx] <= rxByte;
		end
	end

	// decode when the report is complete, stable before reportReq rises
	always_ff @(posedge clk) begin
		if (state == stRelease && !bus.ack && byteIdx == fullIdx) begin
			penDown <= report.fields.header[0];
			touchX <= {report.fields.xHi[4:0], report.fields.xLo[6:0]}; // 5 high + 7 low
			touchY <= {report.fields.yHi[4:0], report.fields.yLo[6:0]};
		end
	end

	assign gapStart = (state == stGapStart); // single cycle pulse
	assign bus.req = (state == stXfer);
	assign bus.txByte = pollByte;
	assign reportReq = (state == stReport);

endmodule

/* verilog/rtpPkg.sv */
//****************************************************************************
// touch panel reader types
// SPI byte, 12-bit coordinate and the five-byte touch report, which is
// seen either as raw bytes or as decoded fields
//****************************************************************************

`include "rtp_defs.svh"

package rtpPkg;

	// one byte on the SPI wires
	typedef logic [7:0] rtpByte_t;

	// X or Y position, 12 bits from the controller ADC
	typedef logic [11:0] coord_t;

	// report as the controller sends it, first byte in the top bits
	//   header : 1 0 0 0 0 0 0 P   (P = pen down)
	//   xLo    : 0 x6 .. x0
	//   xHi    : 0 0 0 x11 .. x7
	//   yLo    : 0 y6 .. y0
	//   yHi    : 0 0 0 y11 .. y7
	typedef struct packed {
		rtpByte_t header;
		rtpByte_t xLo;
		rtpByte_t xHi;
		rtpByte_t yLo;
		rtpByte_t yHi;
	} touchFields_t;

	// same 40 bits, bytes[0] is the header so the array fills in arrival order
	typedef union packed {
		touchFields_t fields;
		rtpByte_t [0:`RTP_REPORT_BYTES-1] bytes;
	} touchReport_u;

endpackage

/* verilog/rtpShifter.sv */
//****************************************************************************
// SPI byte engine
// full-duplex master, one byte per request, 32 clocks per bit with sck high
// for the first 16, sdi sampled at count 15 and the register shifted at 31
//****************************************************************************

`timescale 1ns/10ps
`include "rtp_defs.svh"

module rtpShifter import rtpPkg::*; (
	input logic clk,
	input logic arstN,
	spiByteIf.shifter bus,
	output logic sdo,
	input logic sdi,
	output logic sck
);

	localparam int CntW = $clog2(`RTP_BIT_CYCLES);
	localparam int IdxW = $clog2($bits(rtpByte_t));
	localparam logic [CntW-1:0] lastCnt = CntW'(`RTP_BIT_CYCLES - 1);
	localparam logic [CntW-1:0] sampleCnt = CntW'(`RTP_HALF_CYCLES - 1);
	localparam logic [CntW-1:0] halfCnt = CntW'(`RTP_HALF_CYCLES);
	localparam logic [IdxW-1:0] lastBit = IdxW'($bits(rtpByte_t) - 1);

	logic busy; // a byte is on the wires
	logic ackQ;
	logic [CntW-1:0] bitCnt; // position inside the current bit period
	logic [IdxW-1:0] bitIdx; // which of the eight bits
	rtpByte_t shiftReg; // tx byte shifts out the top, rx bits enter the bottom
	logic sdiHold; // sdi sampled mid-bit
	logic startXfer;
	logic bitEnd;
	logic lastShift;

	// a new request is taken only once the previous ack has dropped
	assign startXfer = bus.req & ~busy & ~ackQ;
	assign bitEnd = busy & (bitCnt == lastCnt);
	assign lastShift = bitEnd & (bitIdx == lastBit);

	// bit period and bit index counters
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			busy <= 1'b0;
			bitCnt <= '0;
			bitIdx <= '0;
		end else if (startXfer) begin
			busy <= 1'b1; // busy from the cycle after req is seen
			bitCnt <= '0;
			bitIdx <= '0;
		end else if (busy) begin
			if (bitEnd) begin
				bitCnt <= '0;
				bitIdx <= bitIdx + 1'b1;
			end else begin
				bitCnt <= bitCnt + 1'b1;
			end
			if (lastShift)
				busy <= 1'b0; // 256 busy cycles in all
		end
	end

	// ack rises with the last shift and falls once req is gone
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			ackQ <= 1'b0;
		else if (lastShift)
			ackQ <= 1'b1;
		else if (ackQ && !bus.req)
			ackQ <= 1'b0;
	end

	// sample sdi at the end of the high phase, just before sck falls
	always_ff @(posedge clk) begin
		if (busy && bitCnt == sampleCnt)
			sdiHold <= sdi;
	end

	// shared tx/rx register, cleared so sdo idles low
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			shiftReg <= '0;
		else if (startXfer)
			shiftReg <= bus.txByte;
		else if (bitEnd)
			shiftReg <= {shiftReg[$bits(rtpByte_t)-2:0], sdiHold}; // slave msb into our lsb
	end

	assign sck = busy & (bitCnt < halfCnt); // high 16, low 16
	assign sdo = shiftReg[$bits(rtpByte_t)-1]; // msb first, always driven
	assign bus.ack = ackQ;
	assign bus.rxByte = shiftReg; // stays put after the last shift

endmodule

/* verilog/spiByteIf.sv */
//****************************************************************************
// SPI byte transfer channel
// four-phase req/ack link between the report sequencer and the shifter,
// one byte out and one byte back per transfer
//****************************************************************************

`timescale 1ns/10ps

interface spiByteIf import rtpPkg::*; ();

	logic req; // master wants a transfer, txByte stable while high
	logic ack; // shifter finished, rxByte valid while high
	rtpByte_t txByte; // byte to shift out on sdo
	rtpByte_t rxByte; // byte gathered from sdi, held until next start

	// report sequencer side
	modport master (
		output req,
		output txByte,
		input ack,
		input rxByte
	);

	// SPI engine side
	modport shifter (
		input req,
		input txByte,
		output ack,
		output rxByte
	);

endinterface

/* verilog/touchPanelTop.sv */
//****************************************************************************
// resistive touch panel reader
// SPI byte engine, inter-byte gap timer and report sequencer, with the
// controller wires and the host report handshake as plain ports
//****************************************************************************

`timescale 1ns/10ps

module touchPanelTop import rtpPkg::*; (
	input logic clk,
	input logic arstN,
	output logic sdo, // to controller SDI
	input logic sdi, // from controller SDO
	output logic sck,
	output logic reportReq,
	input logic reportAck,
	output logic penDown,
	output coord_t touchX,
	output coord_t touchY
);

	logic gapStart;
	logic gapDone;

	// byte channel between sequencer and shifter
	spiByteIf spiBus ();

	rtpShifter uShifter (
		.clk (clk),
		.arstN (arstN),
		.bus (spiBus.shifter),
		.sdo (sdo),
		.sdi (sdi),
		.sck (sck)
	);

	// quiet time between bytes
	gapTimer uGapTimer (
		.clk (clk),
		.arstN (arstN),
		.gapStart (gapStart),
		.gapDone (gapDone)
	);

	reportSequencer uSequencer (
		.clk (clk),
		.arstN (arstN),
		.bus (spiBus.master),
		.gapStart (gapStart),
		.gapDone (gapDone),
		.reportReq (reportReq),
		.reportAck (reportAck),
		.penDown (penDown),
		.touchX (touchX),
		.touchY (touchY)
	);

endmodule
